//--- source/fft_settings.svh
// Size, sample width, twiddle precision and frame latency of the 16-point FFT.
`ifndef FFT_SETTINGS_SVH
`define FFT_SETTINGS_SVH

// points per frame; the datapath is built for exactly sixteen.
`define FFT_POINTS 16

// bits in each real or imaginary part.
`define FFT_WIDTH 16

// twiddle factors are scaled by 2**TWIDDLE_FRAC.
`define TWIDDLE_FRAC 14

// cycles from the edge that samples next to the cycle where next_out is high.
`define FFT_LATENCY 42

`endif

//--- source/fft_pkg.sv
// Package with the complex sample type and the address, stage and twiddle index types.
`default_nettype none

`include "fft_settings.svh"

package fft_pkg;

    // one complex sample, real part in the upper half of the word.
    typedef struct packed {
        logic signed [`FFT_WIDTH-1:0] re;
        logic signed [`FFT_WIDTH-1:0] im;
    } complex_t;

    // address of one word in the sample bank.
    typedef logic [$clog2(`FFT_POINTS)-1:0] addr_t;

    // radix-2 stage number, half span is 2**stage.
    typedef logic [1:0] stage_t;

    // selects W16^k for k from 0 to 7.
    typedef logic [2:0] twiddle_idx_t;

endpackage

`default_nettype wire

//--- source/fft_if.sv
// Interface bfly_if carrying butterfly operands, twiddle index and write-back results.
`default_nettype none

interface bfly_if;

    fft_pkg::addr_t       rd_a;     // read address of the upper operand.
    fft_pkg::addr_t       rd_b;     // read address of the lower operand.
    fft_pkg::twiddle_idx_t tw_idx;
    logic                 issue;    // one butterfly enters the pipeline.
    fft_pkg::complex_t    op_a;
    fft_pkg::complex_t    op_b;
    logic                 wr_en;    // two results are written this cycle.
    fft_pkg::addr_t       wr_a;
    fft_pkg::addr_t       wr_b;
    fft_pkg::complex_t    res_a;
    fft_pkg::complex_t    res_b;

    modport counter (
        output rd_a, rd_b, tw_idx, issue
    );

    modport bank (
        input  rd_a, rd_b,
        output op_a, op_b,
        input  wr_en, wr_a, wr_b, res_a, res_b
    );

    modport butterfly (
        input  issue, op_a, op_b, tw_idx, rd_a, rd_b,
        output wr_en, wr_a, wr_b, res_a, res_b
    );

    modport monitor (
        input rd_a, rd_b, tw_idx, issue, op_a, op_b,
        input wr_en, wr_a, wr_b, res_a, res_b
    );

endinterface

`default_nettype wire

//--- source/fft_sequencer.sv
// Control FSM for frame load, the four butterfly stages, output capture and next_out.
`default_nettype none

`include "fft_settings.svh"

module fft_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic next,
    input  logic stage_done,
    input  logic all_done,
    output logic load,
    output logic run,
    output logic capture,
    output logic next_out
);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        STAGE,
        CAPTURE,
        DONE
    } state_t;

    state_t state;
    state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (next) state_nxt = LOAD;
            LOAD:    state_nxt = STAGE;   // first issue cycle of stage 0.
            STAGE:   if (stage_done && all_done) state_nxt = CAPTURE;
            CAPTURE: state_nxt = DONE;
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign load     = (state == IDLE) && next;  // bank takes the frame on this edge.
    assign run      = (state == LOAD) || (state == STAGE);
    assign capture  = (state == CAPTURE);
    assign next_out = (state == DONE);

    // a frame accepted in IDLE finishes at a fixed distance.
    a_latency: assert property (@(posedge clk) disable iff (rst)
        load |-> ##(`FFT_LATENCY) next_out);

    // each pulse answers the frame accepted that many cycles earlier and never repeats.
    a_single_pulse: assert property (@(posedge clk) disable iff (rst)
        next_out |-> $past(load, `FFT_LATENCY));

endmodule

`default_nettype wire

//--- source/butterfly_counter.sv
// Stage and butterfly counter generating pair addresses, twiddle index and issue.
`default_nettype none

`include "fft_settings.svh"

module butterfly_counter (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic stage_done,
    output logic all_done,
    bfly_if.counter bus
);

    fft_pkg::stage_t stage;
    logic [3:0]      cnt;       // butterflies 0 to 7, then two drain cycles.
    logic [3:0]      half;
    logic [3:0]      j;
    logic [3:0]      lo;
    logic [3:0]      hi;
    logic [3:0]      k;
    fft_pkg::addr_t  addr_a;

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            stage <= '0;
            cnt   <= '0;
        end else if (stage_done) begin
            stage <= stage + 1'b1;
            cnt   <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // a = (j / h) * 2h + (j mod h) and k = (j mod h) * (8 / h).
    always_comb begin
        half = 4'd1 << stage;
        j    = {1'b0, cnt[2:0]};
        lo   = j & (half - 4'd1);
        hi   = (j - lo) << 1;
        k    = lo << (2'd3 - stage);
    end

    assign addr_a      = hi | lo;
    assign bus.rd_a    = addr_a;
    assign bus.rd_b    = addr_a + half;
    assign bus.tw_idx  = k[2:0];
    assign bus.issue   = run && (cnt < 4'(`FFT_POINTS / 2));

    assign stage_done = run && (cnt == 4'(`FFT_POINTS / 2 + 1));
    assign all_done   = stage_done && (stage == 2'd3);

    // the upper address never has the span bit set, so its partner differs only in that bit.
    a_pair_span: assert property (@(posedge clk) disable iff (rst)
        bus.issue |-> ((bus.rd_a & half) == 4'd0) && (bus.rd_b == (bus.rd_a | half)));

endmodule

`default_nettype wire

//--- source/sample_bank.sv
// Sixteen-word complex register bank with bit-reversed load, two reads, two writes and output snapshot.
`default_nettype none

`include "fft_settings.svh"

module sample_bank (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         load,
    input  logic                         capture,
    input  logic signed [`FFT_WIDTH-1:0] x_re [`FFT_POINTS],
    input  logic signed [`FFT_WIDTH-1:0] x_im [`FFT_POINTS],
    output logic signed [`FFT_WIDTH-1:0] y_re [`FFT_POINTS],
    output logic signed [`FFT_WIDTH-1:0] y_im [`FFT_POINTS],
    bfly_if.bank                         bus
);

    fft_pkg::complex_t mem  [`FFT_POINTS];
    fft_pkg::complex_t snap [`FFT_POINTS];

    function automatic fft_pkg::addr_t bit_rev(input fft_pkg::addr_t a);
        return {a[0], a[1], a[2], a[3]};
    endfunction

    // working store: the frame arrives in bit-reversed order, the stages update in place.
    always_ff @(posedge clk) begin
        if (load) begin
            for (int n = 0; n < `FFT_POINTS; n++) begin
                mem[bit_rev(fft_pkg::addr_t'(n))] <= '{re: x_re[n], im: x_im[n]};
            end
        end else if (bus.wr_en) begin
            mem[bus.wr_a] <= bus.res_a;
            mem[bus.wr_b] <= bus.res_b;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            snap <= '{default: '0};
        end else if (capture) begin
            snap <= mem;    // held until the next frame is captured.
        end
    end

    assign bus.op_a = mem[bus.rd_a];
    assign bus.op_b = mem[bus.rd_b];

    always_comb begin
        for (int m = 0; m < `FFT_POINTS; m++) begin
            y_re[m] = snap[m].re;
            y_im[m] = snap[m].im;
        end
    end

    // write-back from the butterfly never collides with itself or with a frame load.
    a_write_ports: assert property (@(posedge clk) disable iff (rst)
        bus.wr_en |-> (bus.wr_a != bus.wr_b) && !load);

endmodule

`default_nettype wire

//--- source/radix2_butterfly.sv
// Two-stage pipelined radix-2 complex butterfly with twiddle table and divide-by-two scaling.
`default_nettype none

`include "fft_settings.svh"

module radix2_butterfly (
    input logic clk,
    input logic rst,
    bfly_if.butterfly bus
);

    fft_pkg::complex_t                w;
    logic signed [2*`FFT_WIDTH-1:0]   p_rr;
    logic signed [2*`FFT_WIDTH-1:0]   p_ii;
    logic signed [2*`FFT_WIDTH-1:0]   p_ri;
    logic signed [2*`FFT_WIDTH-1:0]   p_ir;
    logic signed [2*`FFT_WIDTH:0]     prod_re;
    logic signed [2*`FFT_WIDTH:0]     prod_im;
    logic signed [2*`FFT_WIDTH:0]     sh_re;
    logic signed [2*`FFT_WIDTH:0]     sh_im;

    logic                             v1;
    fft_pkg::complex_t                a1;
    logic signed [`FFT_WIDTH:0]       t1_re;
    logic signed [`FFT_WIDTH:0]       t1_im;
    fft_pkg::addr_t                   wa1;
    fft_pkg::addr_t                   wb1;

    logic signed [`FFT_WIDTH:0]       sum_re;
    logic signed [`FFT_WIDTH:0]       sum_im;
    logic signed [`FFT_WIDTH:0]       dif_re;
    logic signed [`FFT_WIDTH:0]       dif_im;

    logic                             v2;
    fft_pkg::complex_t                r_a2;
    fft_pkg::complex_t                r_b2;
    fft_pkg::addr_t                   wa2;
    fft_pkg::addr_t                   wb2;

    // W16^k in Q1.14, re = cos(2*pi*k/16) and im = -sin(2*pi*k/16).
    function automatic fft_pkg::complex_t twiddle(input fft_pkg::twiddle_idx_t k);
        case (k)
            3'd0:    return '{re:  16'sd16384, im:  16'sd0};
            3'd1:    return '{re:  16'sd15137, im: -16'sd6270};
            3'd2:    return '{re:  16'sd11585, im: -16'sd11585};
            3'd3:    return '{re:  16'sd6270,  im: -16'sd15137};
            3'd4:    return '{re:  16'sd0,     im: -16'sd16384};
            3'd5:    return '{re: -16'sd6270,  im: -16'sd15137};
            3'd6:    return '{re: -16'sd11585, im: -16'sd11585};
            default: return '{re: -16'sd15137, im: -16'sd6270};
        endcase
    endfunction

    function automatic logic signed [`FFT_WIDTH-1:0] halve(input logic signed [`FFT_WIDTH:0] v);
        logic signed [`FFT_WIDTH:0] s;
        s = v >>> 1;
        return s[`FFT_WIDTH-1:0];
    endfunction

    assign w = twiddle(bus.tw_idx);

    // full-width complex product B * W.
    always_comb begin
        p_rr    = bus.op_b.re * w.re;
        p_ii    = bus.op_b.im * w.im;
        p_ri    = bus.op_b.re * w.im;
        p_ir    = bus.op_b.im * w.re;
        prod_re = p_rr - p_ii;
        prod_im = p_ri + p_ir;
        sh_re   = prod_re >>> `TWIDDLE_FRAC;  // rounds toward minus infinity.
        sh_im   = prod_im >>> `TWIDDLE_FRAC;
    end

    always_ff @(posedge clk) begin
        a1    <= bus.op_a;
        t1_re <= sh_re[`FFT_WIDTH:0];
        t1_im <= sh_im[`FFT_WIDTH:0];
        wa1   <= bus.rd_a;
        wb1   <= bus.rd_b;
    end

    // sums wrap at 17 bits before the shift.
    always_comb begin
        sum_re = {a1.re[`FFT_WIDTH-1], a1.re} + t1_re;
        sum_im = {a1.im[`FFT_WIDTH-1], a1.im} + t1_im;
        dif_re = {a1.re[`FFT_WIDTH-1], a1.re} - t1_re;
        dif_im = {a1.im[`FFT_WIDTH-1], a1.im} - t1_im;
    end

    always_ff @(posedge clk) begin
        r_a2 <= '{re: halve(sum_re), im: halve(sum_im)};
        r_b2 <= '{re: halve(dif_re), im: halve(dif_im)};
        wa2  <= wa1;
        wb2  <= wb1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
        end else begin
            v1 <= bus.issue;
            v2 <= v1;
        end
    end

    assign bus.wr_en = v2;
    assign bus.wr_a  = wa2;
    assign bus.wr_b  = wb2;
    assign bus.res_a = r_a2;
    assign bus.res_b = r_b2;

endmodule

`default_nettype wire

//--- source/fft16_core.sv
// Top level of the 16-point FFT connecting sequencer, counter, sample bank and butterfly.
`default_nettype none

`include "fft_settings.svh"

module fft16_core (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         next,
    input  logic signed [`FFT_WIDTH-1:0] x_re [`FFT_POINTS],
    input  logic signed [`FFT_WIDTH-1:0] x_im [`FFT_POINTS],
    output logic                         next_out,
    output logic signed [`FFT_WIDTH-1:0] y_re [`FFT_POINTS],
    output logic signed [`FFT_WIDTH-1:0] y_im [`FFT_POINTS]
);

    logic load;
    logic run;
    logic capture;
    logic stage_done;
    logic all_done;

    bfly_if bus ();

    fft_sequencer seq_i (
        .clk        (clk),
        .rst        (rst),
        .next       (next),
        .stage_done (stage_done),
        .all_done   (all_done),
        .load       (load),
        .run        (run),
        .capture    (capture),
        .next_out   (next_out)
    );

    butterfly_counter cnt_i (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .stage_done (stage_done),
        .all_done   (all_done),
        .bus        (bus.counter)
    );

    sample_bank bank_i (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .capture (capture),
        .x_re    (x_re),
        .x_im    (x_im),
        .y_re    (y_re),
        .y_im    (y_im),
        .bus     (bus.bank)
    );

    // results return to the bank two cycles after issue.
    radix2_butterfly bfly_i (
        .clk (clk),
        .rst (rst),
        .bus (bus.butterfly)
    );

endmodule

`default_nettype wire

//--- test/fft16_model.svh
// Xorshift generator and bit-exact fixed-point 16-point FFT reference model.
`ifndef FFT16_MODEL_SVH
`define FFT16_MODEL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
endfunction

// scales by 2**14 and rounds half away from zero.
function automatic longint round_q14(input real v);
    real s;
    s = v * 16384.0;
    if (s >= 0.0) return longint'($rtoi(s + 0.5));
    return -longint'($rtoi(-s + 0.5));
endfunction

// the sum wraps at 17 bits, then the shift halves it down to 16 bits.
function automatic logic signed [`FFT_WIDTH-1:0] scaled_half(input longint v);
    logic signed [`FFT_WIDTH:0] w;
    w = v[`FFT_WIDTH:0];
    w = w >>> 1;
    return w[`FFT_WIDTH-1:0];
endfunction

task automatic fft_reference(input logic signed [`FFT_WIDTH-1:0] xr [`FFT_POINTS],
                             input logic signed [`FFT_WIDTH-1:0] xi [`FFT_POINTS],
                             output int yr [`FFT_POINTS], output int yi [`FFT_POINTS]);
    fft_pkg::complex_t m [`FFT_POINTS];
    fft_pkg::complex_t a;
    fft_pkg::complex_t b;
    int h, ia, ib, k, rev;
    longint wr, wi, tr, ti;
    real ang;
    for (int n = 0; n < `FFT_POINTS; n++) begin
        rev = ((n & 1) << 3) | ((n & 2) << 1) | ((n & 4) >> 1) | ((n & 8) >> 3);
        m[rev].re = xr[n];
        m[rev].im = xi[n];
    end
    for (int s = 0; s < 4; s++) begin
        h = 1 << s;
        for (int j = 0; j < `FFT_POINTS / 2; j++) begin
            ia = (j / h) * 2 * h + (j % h);
            ib = ia + h;
            k = (j % h) * (8 / h);
            ang = 2.0 * 3.14159265358979 * k / 16.0;
            wr = round_q14($cos(ang));
            wi = round_q14(-$sin(ang));
            a = m[ia];
            b = m[ib];
            tr = (longint'(b.re) * wr - longint'(b.im) * wi) >>> `TWIDDLE_FRAC;
            ti = (longint'(b.re) * wi + longint'(b.im) * wr) >>> `TWIDDLE_FRAC;
            m[ia].re = scaled_half(a.re + tr);
            m[ia].im = scaled_half(a.im + ti);
            m[ib].re = scaled_half(a.re - tr);
            m[ib].im = scaled_half(a.im - ti);
        end
    end
    for (int n = 0; n < `FFT_POINTS; n++) begin
        yr[n] = m[n].re;
        yi[n] = m[n].im;
    end
endtask

`endif

//--- test/fft16_tb.sv
// Testbench for fft16_core with random and directed frames checked against a reference model.
`default_nettype none

`include "fft_settings.svh"

module fft16_tb;

    localparam int TIMEOUT_CYCLES = 16 + 210 * 50 + 500;

    logic clk = 1'b0;
    logic rst;
    logic next;
    logic next_out;
    logic signed [`FFT_WIDTH-1:0] x_re [`FFT_POINTS];
    logic signed [`FFT_WIDTH-1:0] x_im [`FFT_POINTS];
    logic signed [`FFT_WIDTH-1:0] y_re [`FFT_POINTS];
    logic signed [`FFT_WIDTH-1:0] y_im [`FFT_POINTS];

    int exp_re [`FFT_POINTS];
    int exp_im [`FFT_POINTS];
    logic [31:0] rng = 32'd88108;
    int cycles = 0;
    int test_errors = 0;
    int total_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    `include "fft16_model.svh"

    fft16_core dut_i (
        .clk      (clk),
        .rst      (rst),
        .next     (next),
        .x_re     (x_re),
        .x_im     (x_im),
        .next_out (next_out),
        .y_re     (y_re),
        .y_im     (y_im)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_value(input string name, input int expected,
                               input logic signed [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic compare_outputs();
        for (int m = 0; m < `FFT_POINTS; m++) begin
            check_value($sformatf("y_re[%0d]", m), exp_re[m], y_re[m]);
            check_value($sformatf("y_im[%0d]", m), exp_im[m], y_im[m]);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-26s %0d errors", name, test_errors);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic random_inputs();
        for (int n = 0; n < `FFT_POINTS; n++) begin
            rng = xorshift32(rng);
            x_re[n] = rng[15:0];
            x_im[n] = rng[31:16];
        end
    endtask

    task automatic fill_inputs(input int re, input int im);
        for (int n = 0; n < `FFT_POINTS; n++) begin
            x_re[n] = re[`FFT_WIDTH-1:0];
            x_im[n] = im[`FFT_WIDTH-1:0];
        end
    endtask

    // one frame from the current inputs, called on a falling edge with the core idle.
    task automatic run_frame(input bit mid_next);
        int waited;
        fft_reference(x_re, x_im, exp_re, exp_im);
        next = 1'b1;
        @(negedge clk);
        next = 1'b0;
        waited = 1;
        while (next_out !== 1'b1) begin
            next = mid_next && (waited == 12);
            if (next) random_inputs();  // other data that the core must ignore.
            @(negedge clk);
            waited++;
        end
        next = 1'b0;
        check_value("next_out latency", `FFT_LATENCY, waited);
        compare_outputs();
        @(negedge clk);
        check_value("next_out", 0, next_out);
    endtask

    task automatic watch_hold(input int n_cycles, input bit toggle);
        repeat (n_cycles) begin
            if (toggle) random_inputs();
            @(negedge clk);
            check_value("next_out", 0, next_out);
            compare_outputs();
        end
    endtask

    initial begin
        rst = 1'b1;
        next = 1'b0;
        fill_inputs(0, 0);
        repeat (16) @(negedge clk);
        rst = 1'b0;

        exp_re = '{default: 0};
        exp_im = '{default: 0};
        watch_hold(30, 1'b1);
        end_test("reset state");

        repeat (200) begin
            random_inputs();
            run_frame(1'b0);
        end
        end_test("random frames and timing");

        fill_inputs(0, 0);
        x_re[0] = 16'sd8192;
        run_frame(1'b0);
        end_test("impulse");

        fill_inputs(1000, -700);
        run_frame(1'b0);
        end_test("constant");

        fill_inputs(-32768, -32768);
        run_frame(1'b0);
        end_test("full-scale negative");

        random_inputs();
        run_frame(1'b1);
        watch_hold(`FFT_LATENCY + 10, 1'b0);  // a second pulse would show up here.
        end_test("next during frame");

        random_inputs();
        run_frame(1'b0);
        watch_hold(60, 1'b1);
        end_test("output hold");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+source
+incdir+test
source/fft_pkg.sv
source/fft_if.sv
source/fft_sequencer.sv
source/butterfly_counter.sv
source/sample_bank.sv
source/radix2_butterfly.sv
source/fft16_core.sv
test/fft16_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fft16_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
